// File: include/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// data path and pc width
`define XLEN 64

// register file geometry
`define NUM_REGS 32
`define REG_AW 5

// rv64 shift amount field
`define SHAMT_W 6

// control select widths
`define ALUOP_W 3
`define ASEL_W 1   // rs1 or pc
`define BSEL_W 2   // rs2, imm or 4
`define PCSEL_W 2  // plus4, jal, jalr

`endif

// File: rtl/rv_pkg.sv
`include "rv_defs.svh"

package rv_pkg;

    typedef enum logic [1:0] {
        FETCH,
        DECODE,
        EXEC,
        WB
    } state_t;

    typedef enum logic [`ALUOP_W-1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_PASSB   // lui
    } alu_op_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_REG   = 7'b0110011,
        OP_IMM   = 7'b0010011,
        OP_LUI   = 7'b0110111,
        OP_AUIPC = 7'b0010111,
        OP_JAL   = 7'b1101111,
        OP_JALR  = 7'b1100111
    } opcode_t;

    localparam logic [`ASEL_W-1:0]  ASEL_RS1    = 1'b0;
    localparam logic [`ASEL_W-1:0]  ASEL_PC     = 1'b1;
    localparam logic [`BSEL_W-1:0]  BSEL_RS2    = 2'd0;
    localparam logic [`BSEL_W-1:0]  BSEL_IMM    = 2'd1;
    localparam logic [`BSEL_W-1:0]  BSEL_4      = 2'd2;
    localparam logic [`PCSEL_W-1:0] PCSEL_PLUS4 = 2'd0;
    localparam logic [`PCSEL_W-1:0] PCSEL_JAL   = 2'd1;
    localparam logic [`PCSEL_W-1:0] PCSEL_JALR  = 2'd2;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] addr;
    } fetch_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] instr;
    } fetch_rsp_t;

    typedef struct packed {
        logic               valid;
        logic [`XLEN-1:0]   pc;
        logic [31:0]        instr;
        logic [`REG_AW-1:0] rd;
        logic               we;
        logic [`XLEN-1:0]   wdata;
    } retire_t;

    typedef struct packed {
        alu_op_t             alu_op;
        logic [`ASEL_W-1:0]  a_sel;
        logic [`BSEL_W-1:0]  b_sel;
        logic [`PCSEL_W-1:0] pc_sel;
        logic                is_shift;
        logic                rf_we;
        logic [`REG_AW-1:0]  rd;
        logic [`REG_AW-1:0]  rs1;
        logic [`REG_AW-1:0]  rs2;
    } ctrl_t;

endpackage

// File: rtl/ctrl_fsm.sv
`timescale 1ns/1ps

module ctrl_fsm import rv_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  fetch_rsp_t fetch_rsp,
    input  logic       exec_finish,
    output logic       fetch_valid,
    output logic       dec_valid,
    output logic       exec_valid,
    output logic       wb_valid
);

    state_t state;
    state_t state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FETCH;
        end else begin
            state <= state_next;
        end
    end

    // one instruction in flight, no overlap between stages
    always_comb begin
        state_next = state;
        case (state)
            FETCH: begin
                if (fetch_rsp.valid) begin   // wait here for the memory
                    state_next = DECODE;
                end
            end
            DECODE: begin
                state_next = EXEC;
            end
            EXEC: begin
                if (exec_finish) begin   // shifts stay longer
                    state_next = WB;
                end
            end
            WB: begin
                state_next = FETCH;
            end
            default: begin
                state_next = FETCH;
            end
        endcase
    end

    // stage valids, one-hot by construction
    assign fetch_valid = (state == FETCH);
    assign dec_valid   = (state == DECODE);
    assign exec_valid  = (state == EXEC);
    assign wb_valid    = (state == WB);

endmodule

// File: rtl/instr_decoder.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module instr_decoder import rv_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  fetch_rsp_t       fetch_rsp,
    input  logic             dec_valid,
    output logic [31:0]      instr,
    output ctrl_t            ctrl,
    output logic [`XLEN-1:0] imm
);

    logic [31:0]      instr_q;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic             supported;
    ctrl_t            dec;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;
    logic [`XLEN-1:0] imm_next;

    // instruction register, loaded on the memory response
    always_ff @(posedge clk) begin
        if (fetch_rsp.valid) begin
            instr_q <= fetch_rsp.instr;
        end
    end

    assign instr  = instr_q;
    assign funct3 = instr_q[14:12];
    assign funct7 = instr_q[31:25];

    assign imm_i = {{(`XLEN-12){instr_q[31]}}, instr_q[31:20]};
    assign imm_u = {{(`XLEN-32){instr_q[31]}}, instr_q[31:12], 12'b0};
    assign imm_j = {{(`XLEN-21){instr_q[31]}}, instr_q[31], instr_q[19:12],
                    instr_q[20], instr_q[30:21], 1'b0};

    always_comb begin
        dec          = '0;
        dec.alu_op   = ALU_ADD;
        dec.a_sel    = ASEL_RS1;
        dec.b_sel    = BSEL_RS2;
        dec.pc_sel   = PCSEL_PLUS4;
        dec.rd       = instr_q[11:7];
        dec.rs1      = instr_q[19:15];
        dec.rs2      = instr_q[24:20];
        supported    = 1'b0;
        imm_next     = imm_i;
        case (instr_q[6:0])
            OP_REG: begin
                if (funct7 == 7'b0000000) begin
                    supported = 1'b1;
                    case (funct3)
                        3'b000: dec.alu_op = ALU_ADD;
                        3'b001: begin
                            dec.alu_op   = ALU_SLL;
                            dec.is_shift = 1'b1;
                        end
                        3'b100: dec.alu_op = ALU_XOR;
                        3'b101: begin
                            dec.alu_op   = ALU_SRL;
                            dec.is_shift = 1'b1;
                        end
                        3'b110: dec.alu_op = ALU_OR;
                        3'b111: dec.alu_op = ALU_AND;
                        default: supported = 1'b0;   // slt, sltu
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    supported  = 1'b1;
                    dec.alu_op = ALU_SUB;
                end
            end
            OP_IMM: begin
                dec.b_sel = BSEL_IMM;
                supported = 1'b1;
                case (funct3)
                    3'b000: dec.alu_op = ALU_ADD;
                    3'b100: dec.alu_op = ALU_XOR;
                    3'b110: dec.alu_op = ALU_OR;
                    3'b111: dec.alu_op = ALU_AND;
                    3'b001: begin
                        dec.alu_op   = ALU_SLL;
                        dec.is_shift = (instr_q[31:26] == 6'b0);
                        supported    = (instr_q[31:26] == 6'b0);
                    end
                    3'b101: begin
                        dec.alu_op   = ALU_SRL;
                        dec.is_shift = (instr_q[31:26] == 6'b0);   // srai not taken
                        supported    = (instr_q[31:26] == 6'b0);
                    end
                    default: supported = 1'b0;
                endcase
            end
            OP_LUI: begin
                supported  = 1'b1;
                dec.alu_op = ALU_PASSB;
                dec.b_sel  = BSEL_IMM;
                imm_next   = imm_u;
            end
            OP_AUIPC: begin
                supported = 1'b1;
                dec.a_sel = ASEL_PC;
                dec.b_sel = BSEL_IMM;
                imm_next  = imm_u;
            end
            OP_JAL: begin
                supported  = 1'b1;
                dec.a_sel  = ASEL_PC;   // link = pc + 4 through the alu
                dec.b_sel  = BSEL_4;
                dec.pc_sel = PCSEL_JAL;
                imm_next   = imm_j;
            end
            OP_JALR: begin
                if (funct3 == 3'b000) begin
                    supported  = 1'b1;
                    dec.a_sel  = ASEL_PC;
                    dec.b_sel  = BSEL_4;
                    dec.pc_sel = PCSEL_JALR;
                end
            end
            default: ;
        endcase
        dec.rf_we = supported && (dec.rd != '0);   // no write for x0
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl <= '0;
        end else if (dec_valid) begin
            ctrl <= dec;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            imm <= imm_next;
        end
    end

endmodule

// File: rtl/reg_file.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module reg_file (
    input  logic               clk,
    input  logic [`REG_AW-1:0] rs1,
    input  logic [`REG_AW-1:0] rs2,
    output logic [`XLEN-1:0]   rdata1,
    output logic [`XLEN-1:0]   rdata2,
    input  logic               we,
    input  logic [`REG_AW-1:0] waddr,
    input  logic [`XLEN-1:0]   wdata
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    // x0 is never stored
    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // combinational read ports
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: rtl/shift_unit.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module shift_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  logic                left,
    input  logic [`XLEN-1:0]    value,
    input  logic [`SHAMT_W-1:0] shamt,
    output logic                busy,
    output logic                done,
    output logic [`XLEN-1:0]    result
);

    logic [`XLEN-1:0]    data_q;
    logic [`XLEN-1:0]    step;
    logic [`SHAMT_W-1:0] cnt_q;
    logic                load;

    assign load = start && !busy;
    assign step = left ? (data_q << 1) : (data_q >> 1);   // one bit per cycle

    // last step is taken straight from the shifter, zero shift finishes on start
    assign done   = (load && shamt == '0) || (busy && cnt_q == `SHAMT_W'(1));
    assign result = busy ? step : value;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            cnt_q <= '0;
        end else if (load) begin
            busy  <= (shamt != '0);
            cnt_q <= shamt;
        end else if (busy) begin
            cnt_q <= cnt_q - 1'b1;
            if (cnt_q == `SHAMT_W'(1)) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            data_q <= value;
        end else if (busy) begin
            data_q <= step;
        end
    end

endmodule

// File: rtl/exec_unit.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module exec_unit import rv_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               exec_valid,
    input  logic               wb_valid,
    input  ctrl_t              ctrl,
    input  logic [`XLEN-1:0]   imm,
    input  logic [31:0]        instr,
    input  logic [`XLEN-1:0]   rdata1,
    input  logic [`XLEN-1:0]   rdata2,
    output logic               exec_finish,
    output logic               rf_we,
    output logic [`REG_AW-1:0] rf_waddr,
    output logic [`XLEN-1:0]   rf_wdata,
    output logic [`XLEN-1:0]   pc,
    output retire_t            retire
);

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_out;
    logic [`XLEN-1:0] result_q;
    logic [`XLEN-1:0] pc_plus4;
    logic [`XLEN-1:0] jalr_sum;
    logic [`XLEN-1:0] next_pc;
    logic [`XLEN-1:0] shift_out;
    logic             shift_start;
    logic             shift_busy;
    logic             shift_done;

    assign op_a = (ctrl.a_sel == ASEL_PC) ? pc : rdata1;

    always_comb begin
        case (ctrl.b_sel)
            BSEL_IMM: op_b = imm;
            BSEL_4:   op_b = `XLEN'(4);
            default:  op_b = rdata2;
        endcase
    end

    // kicked once on the first exec cycle
    assign shift_start = exec_valid && ctrl.is_shift && !shift_busy;

    shift_unit u_shift_unit (
        .clk    (clk),
        .rst    (rst),
        .start  (shift_start),
        .left   (ctrl.alu_op == ALU_SLL),
        .value  (op_a),
        .shamt  (op_b[`SHAMT_W-1:0]),
        .busy   (shift_busy),
        .done   (shift_done),
        .result (shift_out)
    );

    assign exec_finish = ctrl.is_shift ? shift_done : exec_valid;

    always_comb begin
        case (ctrl.alu_op)
            ALU_SUB:   alu_out = op_a - op_b;
            ALU_AND:   alu_out = op_a & op_b;
            ALU_OR:    alu_out = op_a | op_b;
            ALU_XOR:   alu_out = op_a ^ op_b;
            ALU_SLL,
            ALU_SRL:   alu_out = shift_out;
            ALU_PASSB: alu_out = op_b;
            default:   alu_out = op_a + op_b;   // add, auipc, link
        endcase
    end

    always_ff @(posedge clk) begin
        if (exec_finish) begin
            result_q <= alu_out;
        end
    end

    assign pc_plus4 = pc + `XLEN'(4);
    assign jalr_sum = rdata1 + imm;

    always_comb begin
        case (ctrl.pc_sel)
            PCSEL_JAL:  next_pc = pc + imm;
            PCSEL_JALR: next_pc = {jalr_sum[`XLEN-1:1], 1'b0};
            default:    next_pc = pc_plus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (wb_valid) begin
            pc <= next_pc;
        end
    end

    assign rf_we    = wb_valid && ctrl.rf_we;
    assign rf_waddr = ctrl.rd;
    assign rf_wdata = result_q;

    // pc still holds the retiring instruction's address in wb
    always_comb begin
        retire.valid = wb_valid;
        retire.pc    = pc;
        retire.instr = instr;
        retire.rd    = ctrl.rd;
        retire.we    = ctrl.rf_we;
        retire.wdata = result_q;
    end

endmodule

// File: rtl/rv_core.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_core import rv_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    output fetch_req_t fetch_req,
    input  fetch_rsp_t fetch_rsp,
    output retire_t    retire
);

    logic               fetch_valid;
    logic               dec_valid;
    logic               exec_valid;
    logic               wb_valid;
    logic               exec_finish;
    logic [31:0]        instr;
    ctrl_t              ctrl;
    logic [`XLEN-1:0]   imm;
    logic [`XLEN-1:0]   rdata1;
    logic [`XLEN-1:0]   rdata2;
    logic               rf_we;
    logic [`REG_AW-1:0] rf_waddr;
    logic [`XLEN-1:0]   rf_wdata;
    logic [`XLEN-1:0]   pc;

    // request is held for the whole fetch state
    assign fetch_req.valid = fetch_valid;
    assign fetch_req.addr  = pc;

    ctrl_fsm u_ctrl_fsm (
        .clk         (clk),
        .rst         (rst),
        .fetch_rsp   (fetch_rsp),
        .exec_finish (exec_finish),
        .fetch_valid (fetch_valid),
        .dec_valid   (dec_valid),
        .exec_valid  (exec_valid),
        .wb_valid    (wb_valid)
    );

    instr_decoder u_instr_decoder (
        .clk       (clk),
        .rst       (rst),
        .fetch_rsp (fetch_rsp),
        .dec_valid (dec_valid),
        .instr     (instr),
        .ctrl      (ctrl),
        .imm       (imm)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .rs1    (ctrl.rs1),
        .rs2    (ctrl.rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    exec_unit u_exec_unit (
        .clk         (clk),
        .rst         (rst),
        .exec_valid  (exec_valid),
        .wb_valid    (wb_valid),
        .ctrl        (ctrl),
        .imm         (imm),
        .instr       (instr),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .exec_finish (exec_finish),
        .rf_we       (rf_we),
        .rf_waddr    (rf_waddr),
        .rf_wdata    (rf_wdata),
        .pc          (pc),
        .retire      (retire)
    );

endmodule

// File: sim/rv_core_assertions.sv
`timescale 1ns/1ps

module rv_core_assertions import rv_pkg::*; (
    input logic       clk,
    input logic       rst,
    input fetch_req_t fetch_req,
    input logic       fetch_valid,
    input logic       dec_valid,
    input logic       exec_valid,
    input logic       wb_valid,
    input logic       exec_finish,
    input retire_t    retire
);

    // address held while the request waits
    assert property (@(posedge clk) disable iff (rst)
        fetch_req.valid |=> !fetch_req.valid || $stable(fetch_req.addr))
        else $error("fetch address changed during a pending request");

    assert property (@(posedge clk) disable iff (rst)
        $onehot({fetch_valid, dec_valid, exec_valid, wb_valid}))
        else $error("stage valids are not one-hot");

    assert property (@(posedge clk) disable iff (rst)
        retire.valid |=> !retire.valid)
        else $error("retire valid held for more than one cycle");

    assert property (@(posedge clk) disable iff (rst)
        exec_finish |-> exec_valid)
        else $error("exec finish outside the execute stage");

endmodule

bind rv_core rv_core_assertions u_rv_core_assertions (
    .clk         (clk),
    .rst         (rst),
    .fetch_req   (fetch_req),
    .fetch_valid (fetch_valid),
    .dec_valid   (dec_valid),
    .exec_valid  (exec_valid),
    .wb_valid    (wb_valid),
    .exec_finish (exec_finish),
    .retire      (retire)
);

// File: sim/tb_checker.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module tb_checker import rv_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  fetch_req_t  fetch_req,
    input  retire_t     retire,
    input  logic [31:0] prog [64],
    output int          errors,
    output int          retires
);

    logic [`XLEN-1:0] shadow [`NUM_REGS];
    logic [`XLEN-1:0] exp_pc;

    // expected retire record and next pc from the isa rules
    function automatic retire_t model_retire(
        input  logic [31:0]      ins,
        input  logic [`XLEN-1:0] regs [`NUM_REGS],
        input  logic [`XLEN-1:0] pc,
        output logic [`XLEN-1:0] npc
    );
        retire_t          r;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] imm_i;
        logic [`XLEN-1:0] imm_u;
        logic [`XLEN-1:0] imm_j;
        logic             ok;
        a       = regs[ins[19:15]];
        b       = regs[ins[24:20]];
        imm_i   = `XLEN'($signed(ins[31:20]));
        imm_u   = `XLEN'($signed({ins[31:12], 12'h000}));
        imm_j   = `XLEN'($signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}));
        r       = '0;
        r.valid = 1'b1;
        r.pc    = pc;
        r.instr = ins;
        r.rd    = ins[11:7];
        npc     = pc + `XLEN'(4);
        ok      = 1'b1;
        case (ins[6:0])
            OP_REG: begin
                case ({ins[31:25], ins[14:12]})
                    10'b0000000_000: r.wdata = a + b;
                    10'b0100000_000: r.wdata = a - b;
                    10'b0000000_001: r.wdata = a << b[5:0];
                    10'b0000000_100: r.wdata = a ^ b;
                    10'b0000000_101: r.wdata = a >> b[5:0];
                    10'b0000000_110: r.wdata = a | b;
                    10'b0000000_111: r.wdata = a & b;
                    default:         ok = 1'b0;
                endcase
            end
            OP_IMM: begin
                case (ins[14:12])
                    3'b000: r.wdata = a + imm_i;
                    3'b100: r.wdata = a ^ imm_i;
                    3'b110: r.wdata = a | imm_i;
                    3'b111: r.wdata = a & imm_i;
                    3'b001: begin
                        ok      = (ins[31:26] == 6'b0);
                        r.wdata = a << ins[25:20];
                    end
                    3'b101: begin
                        ok      = (ins[31:26] == 6'b0);   // srai is not in the subset
                        r.wdata = a >> ins[25:20];
                    end
                    default: ok = 1'b0;
                endcase
            end
            OP_LUI:   r.wdata = imm_u;
            OP_AUIPC: r.wdata = pc + imm_u;
            OP_JAL: begin
                r.wdata = pc + `XLEN'(4);
                npc     = pc + imm_j;
            end
            OP_JALR: begin
                ok      = (ins[14:12] == 3'b000);
                r.wdata = pc + `XLEN'(4);
                npc     = ok ? ((a + imm_i) & ~`XLEN'(1)) : npc;
            end
            default: ok = 1'b0;
        endcase
        r.we = ok && (r.rd != 5'd0);
        return r;
    endfunction

    function automatic string op_name(input logic [31:0] ins);
        string name;
        case (ins[14:12])
            3'b000:  name = ins[30] ? "sub" : "add";
            3'b001:  name = "sll";
            3'b100:  name = "xor";
            3'b101:  name = "srl";
            3'b110:  name = "or";
            3'b111:  name = "and";
            default: name = "unsupported";
        endcase
        case (ins[6:0])
            OP_IMM:   name = (ins[14:12] == 3'b000) ? "addi" : {name, "i"};
            OP_LUI:   name = "lui";
            OP_AUIPC: name = "auipc";
            OP_JAL:   name = "jal";
            OP_JALR:  name = "jalr";
            OP_REG:   ;
            default:  name = "unsupported";
        endcase
        return name;
    endfunction

    task automatic check_field(input string test, input string field,
                               input logic [`XLEN-1:0] expected, actual);
        if (actual !== expected) begin
            errors++;
            $display("ERR %s %s: expected %h, actual %h", test, field, expected, actual);
        end
    endtask

    // fetch and retire outputs settle from registers before the falling edge
    always @(negedge clk) begin
        retire_t          exp;
        logic [`XLEN-1:0] npc;
        string            test;
        if (rst) begin
            exp_pc  = '0;
            errors  = 0;
            retires = 0;
            for (int i = 0; i < `NUM_REGS; i++) begin
                shadow[i] = '0;
            end
        end else begin
            if (fetch_req.valid) begin   // request points at the next expected pc
                test = $sformatf("fetch@%0h", exp_pc);
                check_field(test, "addr", exp_pc, fetch_req.addr);
            end
            if (retire.valid) begin
                exp  = model_retire(prog[exp_pc[7:2]], shadow, exp_pc, npc);
                test = $sformatf("%s@%0h", op_name(exp.instr), exp.pc);
                check_field(test, "pc", exp.pc, retire.pc);
                check_field(test, "instr", `XLEN'(exp.instr), `XLEN'(retire.instr));
                check_field(test, "rd", `XLEN'(exp.rd), `XLEN'(retire.rd));
                check_field(test, "we", `XLEN'(exp.we), `XLEN'(retire.we));
                if (exp.we) begin
                    check_field(test, "wdata", exp.wdata, retire.wdata);
                    shadow[exp.rd] = exp.wdata;
                end
                exp_pc = npc;
                retires++;
            end
        end
    end

endmodule

// File: sim/tb_top.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module tb_top import rv_pkg::*; ();

    localparam int NUM_RETIRES = 300;
    localparam int WAIT_LIMIT  = 200;     // in cycles, well above the longest shift
    localparam int RUN_LIMIT   = 40000;

    logic        clk;
    logic        rst;
    fetch_req_t  fetch_req;
    fetch_rsp_t  fetch_rsp;
    retire_t     retire;
    logic [31:0] prog [64];
    logic [31:0] lfsr;
    bit          running;
    bit          fetch_lost;
    int          errors;
    int          retires;

    rv_core rv_core_i (
        .clk       (clk),
        .rst       (rst),
        .fetch_req (fetch_req),
        .fetch_rsp (fetch_rsp),
        .retire    (retire)
    );

    tb_checker u_checker (
        .clk       (clk),
        .rst       (rst),
        .fetch_req (fetch_req),
        .retire    (retire),
        .prog      (prog),
        .errors    (errors),
        .retires   (retires)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic logic [31:0] i_type(input opcode_t op, input logic [2:0] f3,
                                           input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] u_type(input opcode_t op, input logic [4:0] rd,
                                           input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    task automatic build_program();
        logic [3:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        int          tgt;
        for (int i = 0; i < 64; i++) begin
            if (i < 31) begin
                // x1..x31 get a value before anything reads them
                if (i % 2 == 0) begin
                    prog[i] = u_type(OP_LUI, 5'(i + 1), 20'(take_bits(20)));
                end else begin
                    prog[i] = i_type(OP_IMM, 3'b000, 5'(i + 1), 5'(i), 12'(take_bits(12)));
                end
            end else begin
                kind = 4'(take_bits(4));
                rd   = 5'(take_bits(5));
                rs1  = 5'(take_bits(5));
                rs2  = 5'(take_bits(5));
                imm  = 12'(take_bits(12));
                case (kind)
                    4'd0:  prog[i] = r_type(7'b0000000, 3'b000, rd, rs1, rs2);
                    4'd1:  prog[i] = r_type(7'b0100000, 3'b000, rd, rs1, rs2);
                    4'd2:  prog[i] = r_type(7'b0000000, 3'b111, rd, rs1, rs2);
                    4'd3:  prog[i] = r_type(7'b0000000, 3'b110, rd, rs1, rs2);
                    4'd4:  prog[i] = r_type(7'b0000000, 3'b100, rd, rs1, rs2);
                    4'd5:  prog[i] = r_type(7'b0000000, 3'b001, rd, rs1, rs2);
                    4'd6:  prog[i] = r_type(7'b0000000, 3'b101, rd, rs1, rs2);
                    4'd7:  prog[i] = i_type(OP_IMM, 3'b000, rd, rs1, imm);
                    4'd8:  prog[i] = i_type(OP_IMM, 3'b111, rd, rs1, imm);
                    4'd9:  prog[i] = i_type(OP_IMM, 3'b110, rd, rs1, imm);
                    4'd10: prog[i] = i_type(OP_IMM, 3'b100, rd, rs1, imm);
                    4'd11: prog[i] = i_type(OP_IMM, 3'b001, rd, rs1, {6'b0, imm[5:0]});
                    4'd12: prog[i] = i_type(OP_IMM, 3'b101, rd, rs1, {6'b0, imm[5:0]});
                    4'd13: begin
                        prog[i] = u_type(imm[0] ? OP_LUI : OP_AUIPC, rd, 20'(take_bits(20)));
                    end
                    4'd14: begin
                        if (imm[11]) begin
                            prog[i] = i_type(OP_JALR, 3'b000, rd, rs1, imm);
                        end else begin
                            tgt     = (i + 1 + int'(take_bits(3))) % 64;   // forward hop
                            prog[i] = j_type(rd, 21'((tgt - i) * 4));
                        end
                    end
                    default: prog[i] = r_type(7'b0000000, 3'b010, rd, rs1, rs2);   // slt
                endcase
            end
        end
    endtask

    // instruction memory with 0 to 3 wait cycles per request
    initial begin : responder
        int n;
        int gap;
        for (n = 0; !running && n < 50; n++) begin
            @(negedge clk);
        end
        while (!fetch_lost) begin
            for (n = 0; !fetch_req.valid && n < WAIT_LIMIT; n++) begin
                @(negedge clk);
            end
            if (!fetch_req.valid) begin
                $display("core issued no fetch request within %0d cycles", WAIT_LIMIT);
                fetch_lost = 1'b1;
            end else begin
                gap = int'(take_bits(2));
                repeat (gap) @(negedge clk);
                fetch_rsp.valid = 1'b1;
                fetch_rsp.instr = prog[fetch_req.addr[7:2]];   // wraps over 64 words
                @(negedge clk);
                fetch_rsp = '0;
            end
        end
    end

    initial begin : main
        int cycles;
        int timeouts;
        lfsr      = 32'h48c8;
        timeouts  = 0;
        rst       = 1'b1;
        fetch_rsp = '0;
        build_program();
        repeat (4) @(negedge clk);
        rst     = 1'b0;
        running = 1'b1;
        for (cycles = 0; retires < NUM_RETIRES && !fetch_lost && cycles < RUN_LIMIT;
             cycles++) begin
            @(negedge clk);
        end
        if (fetch_lost) begin
            timeouts++;
        end else if (retires < NUM_RETIRES) begin
            $display("only %0d of %0d instructions retired in time", retires, NUM_RETIRES);
            timeouts++;
        end
        $display("retired %0d, errors %0d, timeouts %0d", retires, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+include
rtl/rv_pkg.sv
rtl/ctrl_fsm.sv
rtl/instr_decoder.sv
rtl/reg_file.sv
rtl/shift_unit.sv
rtl/exec_unit.sv
rtl/rv_core.sv
sim/rv_core_assertions.sv
sim/tb_checker.sv
sim/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
OBJ_DIR   ?= obj_dir
FILELIST  ?= tb.f
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := include/rv_defs.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the testbench prints its pass line
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)
